/* common/mci_lite_pkg.sv */
// MCI lite package
// Request, response, privilege and strap types for the subordinate block

`include "mci_lite_settings.svh"

package mci_lite_pkg;

    // Single-word SoC request, forwarded as is to every target
    typedef struct packed {
        logic [`MCI_ADDR_W-1:0] addr;
        logic [`MCI_DATA_W-1:0] wdata;
        logic                   write;
        logic [`MCI_USER_W-1:0] user;
    } soc_req_t;

    // Target side response
    typedef struct packed {
        logic [`MCI_DATA_W-1:0] rdata;
        logic                   hold;
        logic                   error;
    } tgt_rsp_t;

    // Registered response back to the SoC
    typedef struct packed {
        logic [`MCI_DATA_W-1:0] rdata;
        logic                   error;
    } soc_rsp_t;

    // Privileged user flags, all low when no request is active
    typedef struct packed {
        logic mcu_lsu;
        logic mcu_ifu;
        logic mcu;
        logic soc_config;
        logic sram_config;
    } priv_t;

    // Strapped AXI user values
    typedef struct packed {
        logic [`MCI_USER_W-1:0] mcu_lsu;
        logic [`MCI_USER_W-1:0] mcu_ifu;
        logic [`MCI_USER_W-1:0] sram_config;
        logic [`MCI_USER_W-1:0] soc_config;
    } strap_t;

endpackage

/* common/mci_lite_settings.svh */
// MCI lite settings
// Address map, field widths and sizes shared by the package and the RTL

`ifndef MCI_LITE_SETTINGS_SVH
`define MCI_LITE_SETTINGS_SVH

// Request field widths
`define MCI_ADDR_W          32
`define MCI_DATA_W          32
`define MCI_USER_W          32

// Low address bits seen by the decoder, upper bits alias
`define MCI_INTERNAL_ADDR_W 24

// Address windows, sizes in bytes
`define MCI_REG_START       32'h0000_0000
`define MCI_REG_SIZE        4096
`define MCI_MBOX0_START     32'h0040_0000
`define MCI_MBOX1_START     32'h0080_0000
`define MCI_MBOX_SIZE       1024
`define MCI_SRAM_START      32'h00C0_0000
`define MCI_SRAM_SIZE_KB    4

// Implemented words per target
`define MCI_REG_WORDS       16
`define MCI_MBOX_WORDS      16

// Read-only ID in register word 0
`define MCI_LITE_ID         32'h4D43_494C

`endif

/* compile.f */
+incdir+common
common/mci_lite_pkg.sv
source/mci_lite_ingress.sv
sub_decode/mci_lite_sub_decode.sv
source/mci_lite_regs.sv
source/mci_lite_sram.sv
source/mci_lite_mbox.sv
source/mci_lite_top.sv
tests/mci_lite_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the MCI lite testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing -f compile.f --top-module mci_lite_tb -o mci_lite_sim \
    && ./obj_dir/mci_lite_sim > sim.log 2>&1 \
    || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

/* source/mci_lite_ingress.sv */
// MCI lite ingress
// Accepts one SoC request at a time with a valid/ready capture, drives it
// on the internal dv channel until the target drops hold, then returns a
// registered response pulse

`timescale 1ns/1ns

module mci_lite_ingress (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  mci_lite_pkg::soc_req_t req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output mci_lite_pkg::soc_rsp_t rsp,
    output logic                  dv,
    output mci_lite_pkg::soc_req_t dv_req,
    input  mci_lite_pkg::tgt_rsp_t dv_rsp
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t state;
    logic   accept;
    logic   complete;

    // Handshake qualifiers
    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid & req_ready;
    assign dv        = (state == ST_BUSY);
    // Target done once hold drops
    assign complete  = dv & ~dv_rsp.hold;

    //////////////////////////////
    // Control FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= complete;
            case (state)
                ST_IDLE: if (accept) state <= ST_BUSY;
                ST_BUSY: if (complete) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Payload capture
    //////////////////////////////
    // Request stays stable while busy
    always_ff @(posedge clk) begin
        if (accept) begin
            dv_req <= req;
        end
        // Response sampled in the completion cycle
        if (complete) begin
            rsp.rdata <= dv_rsp.rdata;
            rsp.error <= dv_rsp.error;
        end
    end

endmodule

/* source/mci_lite_mbox.sv */
// MCI lite mailbox
// Word 0 is a lock, read to acquire and write to release
// Data words take writes only while locked

`timescale 1ns/1ns

`include "mci_lite_settings.svh"

module mci_lite_mbox (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dv,
    input  mci_lite_pkg::soc_req_t req,
    output mci_lite_pkg::tgt_rsp_t rsp
);

    localparam int OFS_W = $clog2(`MCI_MBOX_SIZE) - 2;
    localparam int IDX_W = $clog2(`MCI_MBOX_WORDS);

    logic [`MCI_DATA_W-1:0] data [1:`MCI_MBOX_WORDS-1];
    logic [OFS_W-1:0]       word_ofs;
    logic [IDX_W-1:0]       word_idx;
    logic                   in_range;
    logic                   lock_q;
    logic                   lock_acc;
    logic                   data_wr;
    logic [`MCI_DATA_W-1:0] rd_word;

    assign word_ofs = req.addr[OFS_W+1:2];
    assign word_idx = word_ofs[IDX_W-1:0];
    assign in_range = (word_ofs < OFS_W'(`MCI_MBOX_WORDS));
    assign lock_acc = dv & in_range & (word_idx == '0);
    // Data write only lands while locked
    assign data_wr  = dv & in_range & req.write & (word_idx != '0) & lock_q;

    //////////////////////////////
    // Lock and data words
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q <= 1'b0;
            for (int i = 1; i < `MCI_MBOX_WORDS; i++) begin
                data[i] <= '0;
            end
        end else begin
            // Read sets the lock, write clears it
            if (lock_acc) lock_q <= ~req.write;
            for (int i = 1; i < `MCI_MBOX_WORDS; i++) begin
                if (data_wr && (word_idx == IDX_W'(i))) data[i] <= req.wdata;
            end
        end
    end

    always_comb begin
        // Old lock bit on word 0
        rd_word = {{(`MCI_DATA_W-1){1'b0}}, lock_q};
        for (int i = 1; i < `MCI_MBOX_WORDS; i++) begin
            if (word_idx == IDX_W'(i)) rd_word = data[i];
        end
        rsp.rdata = (dv & in_range & ~req.write) ? rd_word : '0;
        rsp.hold  = 1'b0;
        rsp.error = dv & (~in_range | (req.write & (word_idx != '0) & ~lock_q));
    end

endmodule

/* source/mci_lite_regs.sv */
// MCI lite control register file
// Word 0 is a read-only ID, the rest are scratch words
// Writes need the soc_config privilege

`timescale 1ns/1ns

`include "mci_lite_settings.svh"

module mci_lite_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dv,
    input  mci_lite_pkg::soc_req_t req,
    input  logic                   soc_config,
    output mci_lite_pkg::tgt_rsp_t rsp
);

    // Word offset inside the window, and index into the implemented words
    localparam int OFS_W = $clog2(`MCI_REG_SIZE) - 2;
    localparam int IDX_W = $clog2(`MCI_REG_WORDS);

    logic [`MCI_DATA_W-1:0] regs [1:`MCI_REG_WORDS-1];
    logic [OFS_W-1:0]       word_ofs;
    logic [IDX_W-1:0]       word_idx;
    logic                   in_range;
    logic                   wr_denied;
    logic                   wr_en;
    logic [`MCI_DATA_W-1:0] rd_word;

    assign word_ofs  = req.addr[OFS_W+1:2];
    assign word_idx  = word_ofs[IDX_W-1:0];
    assign in_range  = (word_ofs < OFS_W'(`MCI_REG_WORDS));
    // Unprivileged write, rejected
    assign wr_denied = req.write & ~soc_config;
    assign wr_en     = dv & in_range & req.write & soc_config;

    //////////////////////////////
    // Scratch registers
    //////////////////////////////
    // Word 0 has no storage, writes there drop silently
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `MCI_REG_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < `MCI_REG_WORDS; i++) begin
                if (wr_en && (word_idx == IDX_W'(i))) begin
                    regs[i] <= req.wdata;
                end
            end
        end
    end

    //////////////////////////////
    // Read mux and response
    //////////////////////////////
    always_comb begin
        rd_word = `MCI_LITE_ID;
        for (int i = 1; i < `MCI_REG_WORDS; i++) begin
            if (word_idx == IDX_W'(i)) begin
                rd_word = regs[i];
            end
        end
    end

    always_comb begin
        // Data only on a good read
        rsp.rdata = (dv & in_range & ~req.write) ? rd_word : '0;
        // Single cycle target
        rsp.hold  = 1'b0;
        rsp.error = dv & (~in_range | wr_denied);
    end

endmodule

/* source/mci_lite_sram.sv */
// MCI lite SRAM
// Word memory with one wait state and a registered read
// Writes need the MCU or SRAM-config privilege

`timescale 1ns/1ns

`include "mci_lite_settings.svh"

module mci_lite_sram (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dv,
    input  mci_lite_pkg::soc_req_t req,
    input  logic                   write_ok,
    output mci_lite_pkg::tgt_rsp_t rsp
);

    localparam int DEPTH = (`MCI_SRAM_SIZE_KB * 1024) / 4;
    localparam int AW    = $clog2(DEPTH);

    logic [`MCI_DATA_W-1:0] mem [DEPTH];
    logic [`MCI_DATA_W-1:0] rdata_q;
    logic [AW-1:0]          word_idx;
    logic                   wait_q;
    logic                   first_cycle;
    logic                   wr_en;

    assign word_idx    = req.addr[AW+1:2];
    // First dv cycle holds, second completes
    assign first_cycle = dv & ~wait_q;
    assign wr_en       = first_cycle & req.write & write_ok;

    // Wait state flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= first_cycle;
        end
    end

    //////////////////////////////
    // Memory array
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (first_cycle) begin
            rdata_q <= mem[word_idx];
            if (wr_en) begin
                mem[word_idx] <= req.wdata;
            end
        end
    end

    always_comb begin
        rsp.rdata = (dv & ~req.write) ? rdata_q : '0;
        rsp.hold  = first_cycle;
        // Rejected write leaves memory alone
        rsp.error = dv & req.write & ~write_ok;
    end

endmodule

/* source/mci_lite_top.sv */
// MCI lite top
// SoC ingress, address decoder, register file, SRAM and two mailboxes

`timescale 1ns/1ns

module mci_lite_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  mci_lite_pkg::soc_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output mci_lite_pkg::soc_rsp_t rsp,
    input  mci_lite_pkg::strap_t   straps,
    output mci_lite_pkg::priv_t    priv
);

    // Internal dv channel
    logic                   dv;
    mci_lite_pkg::soc_req_t dv_req;
    mci_lite_pkg::tgt_rsp_t dv_rsp;

    // Target side
    logic                   reg_dv;
    logic                   sram_dv;
    logic                   mbox0_dv;
    logic                   mbox1_dv;
    mci_lite_pkg::soc_req_t tgt_req;
    mci_lite_pkg::tgt_rsp_t reg_rsp;
    mci_lite_pkg::tgt_rsp_t sram_rsp;
    mci_lite_pkg::tgt_rsp_t mbox0_rsp;
    mci_lite_pkg::tgt_rsp_t mbox1_rsp;
    logic                   sram_write_ok;

    // MCU or SRAM-config users may write the SRAM
    assign sram_write_ok = priv.mcu | priv.sram_config;

    mci_lite_ingress ingress0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .dv(dv), .dv_req(dv_req), .dv_rsp(dv_rsp)
    );

    mci_lite_sub_decode decode0 (
        .clk(clk), .rst_n(rst_n),
        .dv(dv), .req(dv_req), .rsp(dv_rsp),
        .straps(straps), .priv(priv),
        .reg_dv(reg_dv), .sram_dv(sram_dv), .mbox0_dv(mbox0_dv), .mbox1_dv(mbox1_dv),
        .tgt_req(tgt_req),
        .reg_rsp(reg_rsp), .sram_rsp(sram_rsp), .mbox0_rsp(mbox0_rsp), .mbox1_rsp(mbox1_rsp)
    );

    mci_lite_regs regs0 (
        .clk(clk), .rst_n(rst_n), .dv(reg_dv), .req(tgt_req),
        .soc_config(priv.soc_config), .rsp(reg_rsp)
    );

    mci_lite_sram sram0 (
        .clk(clk), .rst_n(rst_n), .dv(sram_dv), .req(tgt_req),
        .write_ok(sram_write_ok), .rsp(sram_rsp)
    );

    mci_lite_mbox mbox0 (
        .clk(clk), .rst_n(rst_n), .dv(mbox0_dv), .req(tgt_req), .rsp(mbox0_rsp)
    );

    mci_lite_mbox mbox1 (
        .clk(clk), .rst_n(rst_n), .dv(mbox1_dv), .req(tgt_req), .rsp(mbox1_rsp)
    );

endmodule

/* sub_decode/mci_lite_sub_decode.sv */
// MCI lite subordinate decode
// Routes the internal request to one of four targets by address range,
// merges the chosen target's response, flags misses as errors and
// detects privileged AXI users from the straps

`timescale 1ns/1ns

`include "mci_lite_settings.svh"

module mci_lite_sub_decode (
    // Clock and reset not needed by the combinational decode
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dv,
    input  mci_lite_pkg::soc_req_t req,
    output mci_lite_pkg::tgt_rsp_t rsp,
    input  mci_lite_pkg::strap_t   straps,
    output mci_lite_pkg::priv_t    priv,
    output logic                   reg_dv,
    output logic                   sram_dv,
    output logic                   mbox0_dv,
    output logic                   mbox1_dv,
    output mci_lite_pkg::soc_req_t tgt_req,
    input  mci_lite_pkg::tgt_rsp_t reg_rsp,
    input  mci_lite_pkg::tgt_rsp_t sram_rsp,
    input  mci_lite_pkg::tgt_rsp_t mbox0_rsp,
    input  mci_lite_pkg::tgt_rsp_t mbox1_rsp
);

    // Window limits, inclusive
    localparam logic [`MCI_ADDR_W-1:0] REG_END   = `MCI_REG_START + `MCI_REG_SIZE - 1;
    localparam logic [`MCI_ADDR_W-1:0] MBOX0_END = `MCI_MBOX0_START + `MCI_MBOX_SIZE - 1;
    localparam logic [`MCI_ADDR_W-1:0] MBOX1_END = `MCI_MBOX1_START + `MCI_MBOX_SIZE - 1;
    localparam logic [`MCI_ADDR_W-1:0] SRAM_END  =
        `MCI_SRAM_START + (`MCI_SRAM_SIZE_KB * 1024) - 1;

    logic [`MCI_ADDR_W-1:0] int_addr;
    logic                   miss;
    logic                   soc_cfg_disable;
    logic                   soc_cfg_force;
    logic                   soc_cfg_match;

    //////////////////////////////
    // Range decode
    //////////////////////////////
    // Upper address bits dropped, so windows alias
    assign int_addr = `MCI_ADDR_W'(req.addr[`MCI_INTERNAL_ADDR_W-1:0]);

    assign reg_dv   = dv & (int_addr inside {[`MCI_REG_START : REG_END]});
    assign mbox0_dv = dv & (int_addr inside {[`MCI_MBOX0_START : MBOX0_END]});
    assign mbox1_dv = dv & (int_addr inside {[`MCI_MBOX1_START : MBOX1_END]});
    assign sram_dv  = dv & (int_addr inside {[`MCI_SRAM_START : SRAM_END]});

    // No window hit
    assign miss = dv & ~(reg_dv | mbox0_dv | mbox1_dv | sram_dv);

    // Same request to every target, dv picks the one that acts
    assign tgt_req = req;

    //////////////////////////////
    // Response merge
    //////////////////////////////
    always_comb begin
        rsp.rdata = '0;
        if (reg_dv) begin
            rsp.rdata = reg_rsp.rdata;
        end else if (sram_dv) begin
            rsp.rdata = sram_rsp.rdata;
        end else if (mbox0_dv) begin
            rsp.rdata = mbox0_rsp.rdata;
        end else if (mbox1_dv) begin
            rsp.rdata = mbox1_rsp.rdata;
        end

        // Only the selected target may stall
        rsp.hold = (reg_dv   & reg_rsp.hold)
                 | (sram_dv  & sram_rsp.hold)
                 | (mbox0_dv & mbox0_rsp.hold)
                 | (mbox1_dv & mbox1_rsp.hold);

        // Miss errors without hold
        rsp.error = (reg_dv   & reg_rsp.error)
                  | (sram_dv  & sram_rsp.error)
                  | (mbox0_dv & mbox0_rsp.error)
                  | (mbox1_dv & mbox1_rsp.error)
                  | miss;
    end

    //////////////////////////////
    // Privileged user detect
    //////////////////////////////
    // All zeros disables the soc_config user
    assign soc_cfg_disable = ~|straps.soc_config;
    // All ones treats every user as soc_config
    assign soc_cfg_force   = &straps.soc_config;
    assign soc_cfg_match   = (req.user == straps.soc_config);

    always_comb begin
        priv.mcu_lsu     = dv & (req.user == straps.mcu_lsu);
        priv.mcu_ifu     = dv & (req.user == straps.mcu_ifu);
        priv.mcu         = priv.mcu_lsu | priv.mcu_ifu;
        priv.sram_config = dv & (req.user == straps.sram_config);
        priv.soc_config  = dv & ((soc_cfg_match & ~soc_cfg_disable) | soc_cfg_force);
    end

endmodule

/* tests/mci_lite_tb.sv */
// MCI lite testbench
// Drives single-word SoC requests into the subordinate block, predicts
// each response with a shadow model and checks data, error, latency,
// req_ready and the privilege flags seen in the dv cycle

`timescale 1ns/1ns

`include "mci_lite_settings.svh"

module mci_lite_tb;

    localparam int CLK_PERIOD = 10;
    localparam int N_RAND     = 200;
    // Upper bound on directed requests
    localparam int N_DIRECTED = 150;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RAND) * 10 + 300;
    localparam int SRAM_WORDS = `MCI_SRAM_SIZE_KB * 256;

    // Strapped users plus one plain user
    localparam logic [`MCI_USER_W-1:0] U_LSU  = 32'h0000_0010;
    localparam logic [`MCI_USER_W-1:0] U_IFU  = 32'h0000_0011;
    localparam logic [`MCI_USER_W-1:0] U_SRAM = 32'h0000_0020;
    localparam logic [`MCI_USER_W-1:0] U_CFG  = 32'h0000_0030;
    localparam logic [`MCI_USER_W-1:0] U_NONE = 32'h0000_0099;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    mci_lite_pkg::soc_req_t req;
    logic                   req_ready;
    logic                   rsp_valid;
    mci_lite_pkg::soc_rsp_t rsp;
    mci_lite_pkg::strap_t   straps;
    mci_lite_pkg::priv_t    priv;

    // Shadow state of the model
    logic [`MCI_DATA_W-1:0] reg_sh  [`MCI_REG_WORDS];
    logic [`MCI_DATA_W-1:0] sram_sh [SRAM_WORDS];
    logic                   mb_lock [2];
    logic [`MCI_DATA_W-1:0] mb_data [2][`MCI_MBOX_WORDS];
    logic [`MCI_USER_W-1:0] users   [5];

    // Outstanding requests in order of issue
    mci_lite_pkg::soc_rsp_t exp_q[$];
    int                     due_q[$];
    string                  what_q[$];

    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    int          n_req = 0;
    int          test_err0;
    int          test_req0;
    string       test_name;
    logic [31:0] lcg_state;

    mci_lite_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .straps(straps), .priv(priv)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Strap match with soc_config all zeros off and all ones on
    function automatic mci_lite_pkg::priv_t ref_priv(input logic [`MCI_USER_W-1:0] user);
        mci_lite_pkg::priv_t p;
        p.mcu_lsu     = (user == straps.mcu_lsu);
        p.mcu_ifu     = (user == straps.mcu_ifu);
        p.mcu         = p.mcu_lsu | p.mcu_ifu;
        p.sram_config = (user == straps.sram_config);
        if (straps.soc_config == '0)
            p.soc_config = 1'b0;
        else if (straps.soc_config == '1)
            p.soc_config = 1'b1;
        else
            p.soc_config = (user == straps.soc_config);
        return p;
    endfunction

    // Expected response and latency in cycles with the shadow state updated
    function automatic mci_lite_pkg::soc_rsp_t ref_access(input mci_lite_pkg::soc_req_t r,
                                                          output int lat);
        mci_lite_pkg::soc_rsp_t e;
        mci_lite_pkg::priv_t    p;
        logic [31:0]            a;
        int                     w;
        int                     k;
        e   = '0;
        lat = 2;
        p   = ref_priv(r.user);
        // Only the low address bits count
        a   = 32'(r.addr[`MCI_INTERNAL_ADDR_W-1:0]);
        if (a < `MCI_REG_START + `MCI_REG_SIZE) begin
            w = int'((a % `MCI_REG_SIZE) >> 2);
            if (w >= `MCI_REG_WORDS)
                e.error = 1'b1;
            else if (r.write) begin
                if (!p.soc_config)
                    e.error = 1'b1;
                else if (w != 0)
                    reg_sh[w] = r.wdata;
            end else
                e.rdata = (w == 0) ? `MCI_LITE_ID : reg_sh[w];
        end else if ((a >= `MCI_MBOX0_START && a < `MCI_MBOX0_START + `MCI_MBOX_SIZE) ||
                     (a >= `MCI_MBOX1_START && a < `MCI_MBOX1_START + `MCI_MBOX_SIZE)) begin
            k = (a >= `MCI_MBOX1_START) ? 1 : 0;
            w = int'((a % `MCI_MBOX_SIZE) >> 2);
            if (w >= `MCI_MBOX_WORDS)
                e.error = 1'b1;
            else if (w == 0) begin
                // Read acquires the lock word and write releases it
                if (r.write)
                    mb_lock[k] = 1'b0;
                else begin
                    e.rdata    = 32'(mb_lock[k]);
                    mb_lock[k] = 1'b1;
                end
            end else if (r.write) begin
                if (mb_lock[k])
                    mb_data[k][w] = r.wdata;
                else
                    e.error = 1'b1;
            end else
                e.rdata = mb_data[k][w];
        end else if (a >= `MCI_SRAM_START && a < `MCI_SRAM_START + SRAM_WORDS * 4) begin
            // One wait state
            lat = 3;
            w   = int'((a - `MCI_SRAM_START) >> 2);
            if (r.write) begin
                if (p.mcu || p.sram_config)
                    sram_sh[w] = r.wdata;
                else
                    e.error = 1'b1;
            end else
                e.rdata = sram_sh[w];
        end else
            e.error = 1'b1;
        return e;
    endfunction

    //////////////////////////////
    // Checks and driver
    //////////////////////////////
    task automatic check_rsp(input mci_lite_pkg::soc_rsp_t got,
                             input mci_lite_pkg::soc_rsp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s returned rdata=%h error=%b, expected rdata=%h error=%b",
                     $time, what, got.rdata, got.error, exp.rdata, exp.error);
        end
    endtask

    task automatic check_priv(input mci_lite_pkg::priv_t got,
                              input mci_lite_pkg::priv_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s priv=%b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s req_ready=%b, expected %b", $time, what, got, exp);
        end
    endtask

    // Called and returning right after a rising edge
    task automatic issue(input logic [31:0] addr, input logic write,
                         input logic [31:0] wdata, input logic [31:0] user, input string what);
        mci_lite_pkg::soc_req_t r;
        mci_lite_pkg::soc_rsp_t e;
        mci_lite_pkg::priv_t    ep;
        int                     lat;
        r.addr    = addr;
        r.wdata   = wdata;
        r.write   = write;
        r.user    = user;
        ep        = ref_priv(user);
        e         = ref_access(r, lat);
        n_req++;
        req_valid <= 1'b1;
        req       <= r;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        // Idle, so no flag may be set
        check_priv(priv, '0, {what, " before accept"});
        // Accepted on the coming edge
        exp_q.push_back(e);
        due_q.push_back(cyc + lat);
        what_q.push_back(what);
        @(posedge clk);
        req_valid <= 1'b0;
        // dv cycle
        @(negedge clk);
        check_priv(priv, ep, what);
        check_ready(req_ready, 1'b0, {what, " in flight"});
        @(posedge clk);
    endtask

    // Responses compared in order of arrival
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected response at %0t ns with no request outstanding", $time);
            end else begin
                check_rsp(rsp, exp_q[0], what_q[0]);
                // Ready again together with the response
                check_ready(req_ready, 1'b1, what_q[0]);
                if (cyc != due_q[0]) begin
                    errors++;
                    $display("[ERROR] %0t ns: %s response in cycle %0d, expected cycle %0d",
                             $time, what_q[0], cyc, due_q[0]);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                void'(what_q.pop_front());
            end
        end
    end

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Missing response: %0d request(s) never got a response", exp_q.size());
            exp_q.delete();
            due_q.delete();
            what_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
        test_req0 = n_req;
    endtask

    task automatic end_test();
        drain();
        $display("test %s: %0d requests, %0d errors", test_name, n_req - test_req0,
                 errors - test_err0);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        int          i;
        int          k;
        int          w;
        logic [31:0] r;
        logic [31:0] base;
        logic [31:0] addr;
        lcg_state          = 32'ha221_d26f;
        rst_n              = 1'b0;
        req_valid          = 1'b0;
        req                = '0;
        straps.mcu_lsu     = U_LSU;
        straps.mcu_ifu     = U_IFU;
        straps.sram_config = U_SRAM;
        straps.soc_config  = U_CFG;
        users[0] = U_LSU;
        users[1] = U_IFU;
        users[2] = U_SRAM;
        users[3] = U_CFG;
        users[4] = U_NONE;
        for (i = 0; i < `MCI_REG_WORDS; i++) begin
            reg_sh[i]     = '0;
            mb_data[0][i] = '0;
            mb_data[1][i] = '0;
        end
        mb_lock[0] = 1'b0;
        mb_lock[1] = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start_test("regs");
        issue(`MCI_REG_START, 1'b0, '0, U_NONE, "ID read");
        for (i = 1; i < `MCI_REG_WORDS; i++)
            issue(`MCI_REG_START + 32'(i * 4), 1'b1, rand32(), U_CFG, "scratch write");
        for (i = 1; i < `MCI_REG_WORDS; i++)
            issue(`MCI_REG_START + 32'(i * 4), 1'b0, '0, U_CFG, "scratch read");
        issue(`MCI_REG_START + 12, 1'b1, 32'h0BAD_0003, U_LSU, "unprivileged reg write");
        issue(`MCI_REG_START + 12, 1'b0, '0, U_NONE, "scratch recheck");
        issue(`MCI_REG_START, 1'b1, 32'h1234_5678, U_CFG, "ID write");
        issue(`MCI_REG_START, 1'b0, '0, U_CFG, "ID reread");
        issue(`MCI_REG_START + 32'h40, 1'b0, '0, U_CFG, "reg word 16 read");
        issue(`MCI_REG_START + 32'hFFC, 1'b1, 32'h1, U_CFG, "last reg word write");
        end_test();

        start_test("sram");
        for (i = 0; i < 16; i++)
            issue(`MCI_SRAM_START + 32'(i * 4), 1'b1, rand32(), users[i % 3], "SRAM write");
        for (i = 0; i < 16; i++)
            issue(`MCI_SRAM_START + 32'(i * 4), 1'b0, '0, U_NONE, "SRAM read");
        issue(`MCI_SRAM_START + 20, 1'b1, 32'hDEAD_0005, U_NONE, "unprivileged SRAM write");
        issue(`MCI_SRAM_START + 20, 1'b0, '0, U_NONE, "SRAM recheck");
        issue(`MCI_SRAM_START + 32'hFFC, 1'b1, rand32(), U_SRAM, "SRAM top write");
        issue(`MCI_SRAM_START + 32'hFFC, 1'b0, '0, U_LSU, "SRAM top read");
        end_test();

        start_test("mbox");
        for (k = 0; k < 2; k++) begin
            base = (k == 1) ? `MCI_MBOX1_START : `MCI_MBOX0_START;
            issue(base + 8, 1'b1, 32'hD00D_0000 + 32'(k), U_NONE, "unlocked data write");
            issue(base, 1'b0, '0, U_NONE, "first lock read");
            issue(base, 1'b0, '0, U_NONE, "second lock read");
            issue(base + 8, 1'b1, 32'hCAFE_0000 + 32'(k), U_NONE, "locked data write");
            issue(base + 8, 1'b0, '0, U_NONE, "mailbox data read");
            issue(base + 32'h40, 1'b0, '0, U_NONE, "mailbox word 16 read");
        end
        // Release mbox0 only
        issue(`MCI_MBOX0_START, 1'b1, '0, U_NONE, "mbox0 lock clear");
        issue(`MCI_MBOX1_START, 1'b0, '0, U_NONE, "mbox1 lock still set");
        issue(`MCI_MBOX0_START + 8, 1'b1, 32'h0BAD_0008, U_NONE, "write after clear");
        issue(`MCI_MBOX0_START, 1'b0, '0, U_NONE, "mbox0 relock read");
        end_test();

        start_test("decode");
        issue(32'h0000_1000, 1'b0, '0, U_NONE, "gap after regs");
        issue(32'h0040_0400, 1'b0, '0, U_NONE, "gap after mbox0");
        issue(32'h0080_0400, 1'b0, '0, U_NONE, "gap after mbox1");
        issue(32'h00C0_1000, 1'b0, '0, U_NONE, "gap after SRAM");
        issue(32'h00FF_FFFC, 1'b1, 32'h1, U_CFG, "top of space write");
        issue(32'h5A00_0000, 1'b0, '0, U_NONE, "aliased ID read");
        issue(32'hFFC0_000C, 1'b0, '0, U_NONE, "aliased SRAM read");
        issue(32'h8000_0010, 1'b1, 32'h600D_0004, U_CFG, "aliased reg write");
        issue(32'h0000_0010, 1'b0, '0, U_NONE, "reg read after alias");
        issue(32'h3340_0000, 1'b0, '0, U_NONE, "aliased mbox0 lock read");
        end_test();

        start_test("priv");
        for (i = 0; i < 5; i++)
            issue(`MCI_REG_START + 20, 1'b1, rand32(), users[i], "priv write");
        straps.soc_config <= '0;
        @(posedge clk);
        issue(`MCI_REG_START + 20, 1'b1, 32'h0000_0505, '0, "zero user, strap off");
        issue(`MCI_REG_START + 20, 1'b1, 32'h0000_0606, U_CFG, "config user, strap off");
        issue(`MCI_REG_START + 20, 1'b0, '0, U_NONE, "reg read, strap off");
        straps.soc_config <= '1;
        @(posedge clk);
        issue(`MCI_REG_START + 20, 1'b1, 32'h0000_0707, U_NONE, "plain user, strap forced");
        issue(`MCI_REG_START + 20, 1'b0, '0, U_LSU, "reg read, strap forced");
        straps.soc_config <= U_CFG;
        @(posedge clk);
        end_test();

        start_test("random");
        for (i = 0; i < N_RAND; i++) begin
            r = rand32();
            repeat (int'(r[1:0])) @(posedge clk);
            // Lock word picked often and a few offsets past the implemented words
            w = r[16] ? 0 : int'(r[10:6]) % 18;
            case (int'(r[13:11]) % 5)
                0: addr = `MCI_REG_START + 32'(w * 4);
                1: addr = `MCI_SRAM_START + 32'((w % 16) * 4);
                2: addr = `MCI_MBOX0_START + 32'(w * 4);
                3: addr = `MCI_MBOX1_START + 32'(w * 4);
                default: addr = 32'h0010_0000 | {12'h000, r[19:2], 2'b00};
            endcase
            addr[31:24] = r[31:24];
            issue(addr, r[5], rand32(), users[int'(r[4:2]) % 5], "random access");
        end
        end_test();

        $display("Summary: %0d requests, %0d checks, %0d errors", n_req, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
